/* design/mult_pkg.sv */
package mult_pkg;

  ////////////////////
  // Array shape
  ////////////////////

  // Total lanes and how many of them sit on DSP slices
  localparam int lane_num     = 8;
  localparam int dsp_lane_num = 6;

  // Per-lane word widths on the flat vectors
  localparam int a_width = 24;
  localparam int b_width = 16;
  localparam int p_width = 40;

  // DSP core ports, B widened to the slice's 18-bit input
  localparam int dsp_b_width = 18;
  localparam int dsp_p_width = 42;

  // Fabric core operands, signed A times unsigned B
  localparam int lut_a_width = 16;
  localparam int lut_b_width = 8;
  localparam int lut_p_width = 24;
  // B bits summed per adder stage in the fabric core
  localparam int lut_nib_width = lut_b_width / 2;

  // Enabled cycles from operand sample to product, same for both cores
  localparam int mult_latency = 3;

  ////////////////////
  // Lane operand words
  ////////////////////

  // A word, full signed for DSP lanes, low 16 bits for fabric lanes
  typedef union packed {
    logic signed [a_width-1:0] dsp;
    struct packed {
      logic        [a_width-lut_a_width-1:0] hi;
      logic signed [lut_a_width-1:0]         val;
    } lut;
  } lane_a_u;

  // B word, signed for DSP lanes, unsigned low byte for fabric lanes
  typedef union packed {
    logic signed [b_width-1:0] dsp;
    struct packed {
      logic [b_width-lut_b_width-1:0] hi;
      logic [lut_b_width-1:0]         val;
    } lut;
  } lane_b_u;

endpackage

/* design/mult_lane_if.sv */
interface mult_lane_if;

  // Shared clock enable, copied into every lane
  logic en;

  // Operand words, decoded per lane kind through the unions
  mult_pkg::lane_a_u a;
  mult_pkg::lane_b_u b;

  // Product already sized to the output vector slice
  logic [mult_pkg::p_width-1:0] p;

  // Array side drives operands and collects the product
  modport array (
    output en,
    output a,
    output b,
    input  p
  );

  // Multiplier side consumes operands and returns the product
  modport mult (
    input  en,
    input  a,
    input  b,
    output p
  );

endinterface

/* design/mult_dsp_s24_s18.sv */
module mult_dsp_s24_s18 (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    ce,
  input  logic signed [mult_pkg::a_width-1:0]     a,
  input  logic signed [mult_pkg::dsp_b_width-1:0] b,
  output logic signed [mult_pkg::dsp_p_width-1:0] p
);

  ////////////////////
  // Pipeline registers
  ////////////////////

  // Input registers, like the slice's A and B regs
  logic signed [mult_pkg::a_width-1:0]     a_q;
  logic signed [mult_pkg::dsp_b_width-1:0] b_q;

  // Multiplier register
  logic signed [mult_pkg::dsp_p_width-1:0] m_q;

  // Output register chain, one deep at the default latency
  logic signed [mult_pkg::dsp_p_width-1:0] out_q [mult_pkg::mult_latency-2];

  always_ff @(posedge clk) begin
    if (rst) begin
      a_q <= '0;
      b_q <= '0;
      m_q <= '0;
      for (int s = 0; s < mult_pkg::mult_latency - 2; s++) begin
        out_q[s] <= '0;
      end
    end else if (ce) begin
      // Stage 1, capture operands
      a_q <= a;
      b_q <= b;
      // Stage 2, exact signed product in 42 bits
      m_q <= a_q * b_q;
      // Stage 3, output register
      out_q[0] <= m_q;
      // Extra output stages only if latency is raised
      for (int s = 1; s < mult_pkg::mult_latency - 2; s++) begin
        out_q[s] <= out_q[s-1];
      end
    end
  end

  // Last output stage drives the port
  assign p = out_q[mult_pkg::mult_latency-3];

endmodule

/* design/mult_lut_s16_u8.sv */
module mult_lut_s16_u8 (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    ce,
  input  logic signed [mult_pkg::lut_a_width-1:0] a,
  input  logic        [mult_pkg::lut_b_width-1:0] b,
  output logic signed [mult_pkg::lut_p_width-1:0] p
);

  // A sign-extended to the product width, before and after stage 1
  logic signed [mult_pkg::lut_p_width-1:0] a_ext;
  logic signed [mult_pkg::lut_p_width-1:0] s1_a_ext;

  // Combinational partial sums for each nibble of B
  logic signed [mult_pkg::lut_p_width-1:0] lo_sum;
  logic signed [mult_pkg::lut_p_width-1:0] hi_sum;

  // Stage 1 keeps A and the upper nibble for the second adder
  logic signed [mult_pkg::lut_a_width-1:0]   s1_a;
  logic        [mult_pkg::lut_nib_width-1:0] s1_b_hi;
  logic signed [mult_pkg::lut_p_width-1:0]   s1_sum;

  // Stage 2 sum and output chain
  logic signed [mult_pkg::lut_p_width-1:0] s2_sum;
  logic signed [mult_pkg::lut_p_width-1:0] out_q [mult_pkg::mult_latency-2];

  ////////////////////
  // Shift-add terms
  ////////////////////

  assign a_ext    = {{(mult_pkg::lut_p_width - mult_pkg::lut_a_width){a[mult_pkg::lut_a_width-1]}}, a};
  assign s1_a_ext = {{(mult_pkg::lut_p_width - mult_pkg::lut_a_width){s1_a[mult_pkg::lut_a_width-1]}},
                     s1_a};

  // B bits 0 to 3, shifted copies of A for each set bit
  always_comb begin
    lo_sum = '0;
    for (int k = 0; k < mult_pkg::lut_nib_width; k++) begin
      if (b[k]) begin
        lo_sum = lo_sum + (a_ext <<< k);
      end
    end
  end

  // B bits 4 to 7 added on top of the stage 1 sum
  // B is unsigned so no negative weight on its top bit
  always_comb begin
    hi_sum = s1_sum;
    for (int k = 0; k < mult_pkg::lut_nib_width; k++) begin
      if (s1_b_hi[k]) begin
        hi_sum = hi_sum + (s1_a_ext <<< (k + mult_pkg::lut_nib_width));
      end
    end
  end

  ////////////////////
  // Pipeline registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_a    <= '0;
      s1_b_hi <= '0;
      s1_sum  <= '0;
      s2_sum  <= '0;
      for (int s = 0; s < mult_pkg::mult_latency - 2; s++) begin
        out_q[s] <= '0;
      end
    end else if (ce) begin
      // Stage 1
      s1_a    <= a;
      s1_b_hi <= b[mult_pkg::lut_b_width-1:mult_pkg::lut_nib_width];
      s1_sum  <= lo_sum;
      // Stage 2
      s2_sum  <= hi_sum;
      // Stage 3, final sum registered
      out_q[0] <= s2_sum;
      for (int s = 1; s < mult_pkg::mult_latency - 2; s++) begin
        out_q[s] <= out_q[s-1];
      end
    end
  end

  assign p = out_q[mult_pkg::mult_latency-3];

endmodule

/* design/mult_array_hete.sv */
module mult_array_hete (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            en,
  input  logic [mult_pkg::lane_num*mult_pkg::a_width-1:0] vector_a,
  input  logic [mult_pkg::lane_num*mult_pkg::b_width-1:0] vector_b,
  output logic [mult_pkg::lane_num*mult_pkg::p_width-1:0] vector_p
);

  ////////////////////
  // DSP lanes
  ////////////////////

  for (genvar i = 0; i < mult_pkg::dsp_lane_num; i++) begin : g_dsp
    mult_lane_if lane ();

    // Full 42-bit product straight from the core
    logic signed [mult_pkg::dsp_p_width-1:0] p_raw;

    // Lane slice of the flat vectors
    assign lane.en = en;
    assign lane.a  = vector_a[i*mult_pkg::a_width +: mult_pkg::a_width];
    assign lane.b  = vector_b[i*mult_pkg::b_width +: mult_pkg::b_width];

    // B sign-extended to the 18-bit slice port
    mult_dsp_s24_s18 u_mult (
      .clk (clk),
      .rst (rst),
      .ce  (lane.en),
      .a   (lane.a.dsp),
      .b   ({{(mult_pkg::dsp_b_width - mult_pkg::b_width){lane.b.dsp[mult_pkg::b_width-1]}},
             lane.b.dsp}),
      .p   (p_raw)
    );

    // Keep low 40 bits only
    assign lane.p = p_raw[mult_pkg::p_width-1:0];
    assign vector_p[i*mult_pkg::p_width +: mult_pkg::p_width] = lane.p;
  end

  ////////////////////
  // Fabric lanes
  ////////////////////

  for (genvar i = mult_pkg::dsp_lane_num; i < mult_pkg::lane_num; i++) begin : g_lut
    mult_lane_if lane ();

    // 24-bit product of the shift-add core
    logic signed [mult_pkg::lut_p_width-1:0] p_raw;

    assign lane.en = en;
    assign lane.a  = vector_a[i*mult_pkg::a_width +: mult_pkg::a_width];
    assign lane.b  = vector_b[i*mult_pkg::b_width +: mult_pkg::b_width];

    // Upper bits of both words are dropped by the lut view
    mult_lut_s16_u8 u_mult (
      .clk (clk),
      .rst (rst),
      .ce  (lane.en),
      .a   (lane.a.lut.val),
      .b   (lane.b.lut.val),
      .p   (p_raw)
    );

    // Sign-extend to the common product width
    assign lane.p = {{(mult_pkg::p_width - mult_pkg::lut_p_width){p_raw[mult_pkg::lut_p_width-1]}},
                     p_raw};
    assign vector_p[i*mult_pkg::p_width +: mult_pkg::p_width] = lane.p;
  end

endmodule

/* design/mult_array_top.sv */
module mult_array_top (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            en,
  input  logic [mult_pkg::lane_num*mult_pkg::a_width-1:0] vector_a,
  input  logic [mult_pkg::lane_num*mult_pkg::b_width-1:0] vector_b,
  output logic [mult_pkg::lane_num*mult_pkg::p_width-1:0] vector_p
);

  // Products from the array, no extra register at this level
  logic [mult_pkg::lane_num*mult_pkg::p_width-1:0] array_p;

  ////////////////////
  // Multiplier array
  ////////////////////

  // Lanes 0 to 5 on DSP, 6 and 7 on fabric
  mult_array_hete u_array (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .vector_a (vector_a),
    .vector_b (vector_b),
    .vector_p (array_p)
  );

  assign vector_p = array_p;

endmodule

/* tb/mult_array_sva.sv */
module mult_array_sva (
  input logic                                            clk,
  input logic                                            rst,
  input logic                                            en,
  input logic [mult_pkg::lane_num*mult_pkg::p_width-1:0] vector_p
);

  // Count of assertion failures
  int fail_count = 0;

  // Every pipeline stage clears on a reset edge, so the products read zero
  reset_clears_products: assert property (@(posedge clk) rst |=> (vector_p == '0))
    else begin
      $error("vector_p not zero after a reset edge");
      fail_count++;
    end

  // An edge with en low must leave the products untouched
  hold_when_disabled: assert property (@(posedge clk) disable iff (rst)
    !en |=> $stable(vector_p))
    else begin
      $error("vector_p changed across an edge with en low");
      fail_count++;
    end

  // Once out of reset no lane may carry unknown bits
  products_known: assert property (@(posedge clk) !rst |-> !$isunknown(vector_p))
    else begin
      $error("vector_p has unknown bits out of reset");
      fail_count++;
    end

endmodule

bind mult_array_hete mult_array_sva sva_i (
  .clk      (clk),
  .rst      (rst),
  .en       (en),
  .vector_p (vector_p)
);

/* tb/mult_array_checker.sv */
module mult_array_checker (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            en,
  input  logic [mult_pkg::lane_num*mult_pkg::a_width-1:0] vector_a,
  input  logic [mult_pkg::lane_num*mult_pkg::b_width-1:0] vector_b,
  input  logic [mult_pkg::lane_num*mult_pkg::p_width-1:0] vector_p,
  output int                                              error_count,
  output int                                              compare_count
);

  localparam int pv_width = mult_pkg::lane_num * mult_pkg::p_width;

  // Expected words in flight, one per enabled stage, oldest at the top
  logic [pv_width-1:0] pipe [mult_pkg::mult_latency];
  // Set once a reset edge has defined the DUT state
  logic primed;

  // Reference products straight from the lane rules
  function automatic logic [pv_width-1:0] expected_products(
    input logic [mult_pkg::lane_num*mult_pkg::a_width-1:0] va,
    input logic [mult_pkg::lane_num*mult_pkg::b_width-1:0] vb
  );
    logic [pv_width-1:0]                     pv;
    logic signed [mult_pkg::a_width-1:0]     a_full;
    logic signed [mult_pkg::b_width-1:0]     b_full;
    logic signed [mult_pkg::lut_a_width-1:0] a_low;
    logic        [mult_pkg::lut_b_width-1:0] b_low;
    longint                                  a_val;
    longint                                  b_val;
    longint                                  prod;
    pv = '0;
    for (int i = 0; i < mult_pkg::lane_num; i++) begin
      a_full = va[i*mult_pkg::a_width +: mult_pkg::a_width];
      b_full = vb[i*mult_pkg::b_width +: mult_pkg::b_width];
      if (i < mult_pkg::dsp_lane_num) begin
        // Signed times signed, whole words
        a_val = a_full;
        b_val = b_full;
      end else begin
        // Signed low half of A times unsigned low byte of B
        a_low = a_full[mult_pkg::lut_a_width-1:0];
        b_low = b_full[mult_pkg::lut_b_width-1:0];
        a_val = a_low;
        b_val = b_low;
      end
      prod = a_val * b_val;
      pv[i*mult_pkg::p_width +: mult_pkg::p_width] = prod[mult_pkg::p_width-1:0];
    end
    return pv;
  endfunction

  initial begin
    primed        = 1'b0;
    error_count   = 0;
    compare_count = 0;
  end

  ////////////////////
  // Latency model
  ////////////////////

  always @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < mult_pkg::mult_latency; s++) begin
        pipe[s] = '0;
      end
      primed = 1'b1;
    end else if (en) begin
      // Advance only on enabled edges
      for (int s = mult_pkg::mult_latency - 1; s > 0; s--) begin
        pipe[s] = pipe[s-1];
      end
      pipe[0] = expected_products(vector_a, vector_b);
    end
  end

  ////////////////////
  // Compare
  ////////////////////

  // Falling edge, outputs settled since the last rising edge
  always @(negedge clk) begin
    if (primed) begin
      compare_count++;
      for (int i = 0; i < mult_pkg::lane_num; i++) begin
        if (vector_p[i*mult_pkg::p_width +: mult_pkg::p_width] !==
            pipe[mult_pkg::mult_latency-1][i*mult_pkg::p_width +: mult_pkg::p_width]) begin
          error_count++;
          $display("MISMATCH vector_p lane %0d: got %h, expected %h", i,
                   vector_p[i*mult_pkg::p_width +: mult_pkg::p_width],
                   pipe[mult_pkg::mult_latency-1][i*mult_pkg::p_width +: mult_pkg::p_width]);
        end
      end
    end
  end

endmodule

/* tb/tb_mult_array.sv */
module tb_mult_array;

  localparam int clk_period     = 20;
  localparam int drive_delay    = 2;
  localparam int reset_cycles   = 3;
  localparam int row_num        = 24;
  localparam int timeout_cycles = (row_num + mult_pkg::mult_latency + reset_cycles) * 2;

  localparam int av_width = mult_pkg::lane_num * mult_pkg::a_width;
  localparam int bv_width = mult_pkg::lane_num * mult_pkg::b_width;
  localparam int pv_width = mult_pkg::lane_num * mult_pkg::p_width;

  // Operand kinds
  localparam logic [2:0] kind_rand = 3'd0;
  localparam logic [2:0] kind_max  = 3'd1;
  localparam logic [2:0] kind_min  = 3'd2;
  localparam logic [2:0] kind_zero = 3'd3;
  localparam logic [2:0] kind_neg1 = 3'd4;
  localparam logic [2:0] kind_mix  = 3'd5;

  logic                clk;
  logic                rst;
  logic                en;
  logic [av_width-1:0] vector_a;
  logic [bv_width-1:0] vector_b;
  logic [pv_width-1:0] vector_p;

  int seed;
  int cycle_count;
  int tb_errors;
  int sva_errors;
  int error_count;
  int compare_count;

  // Row is en above the operand kind
  // En-low runs sit between enabled bursts to stall words mid-pipe
  logic [3:0] stim_tbl [row_num] = '{
    {1'b1, kind_zero}, {1'b1, kind_max},  {1'b1, kind_min},  {1'b1, kind_neg1},
    {1'b1, kind_mix},  {1'b1, kind_rand}, {1'b0, kind_rand}, {1'b0, kind_rand},
    {1'b1, kind_rand}, {1'b1, kind_rand}, {1'b1, kind_max},  {1'b0, kind_rand},
    {1'b1, kind_min},  {1'b1, kind_rand}, {1'b1, kind_rand}, {1'b0, kind_rand},
    {1'b1, kind_rand}, {1'b1, kind_neg1}, {1'b1, kind_mix},  {1'b0, kind_rand},
    {1'b0, kind_rand}, {1'b1, kind_rand}, {1'b1, kind_rand}, {1'b1, kind_rand}
  };

  mult_array_top dut_i (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .vector_a (vector_a),
    .vector_b (vector_b),
    .vector_p (vector_p)
  );

  mult_array_checker chk_i (
    .clk           (clk),
    .rst           (rst),
    .en            (en),
    .vector_a      (vector_a),
    .vector_b      (vector_b),
    .vector_p      (vector_p),
    .error_count   (error_count),
    .compare_count (compare_count)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Fills every lane for one row
  task automatic build_operands(input logic [2:0] kind, output logic [av_width-1:0] va,
                                output logic [bv_width-1:0] vb);
    logic [mult_pkg::a_width-1:0]     a_w;
    logic [mult_pkg::b_width-1:0]     b_w;
    logic [mult_pkg::lut_a_width-1:0] la;
    logic [mult_pkg::lut_b_width-1:0] lb;
    va = '0;
    vb = '0;
    for (int i = 0; i < mult_pkg::lane_num; i++) begin
      if (i < mult_pkg::dsp_lane_num) begin
        case (kind)
          kind_zero: a_w = 24'h000000;
          kind_max:  a_w = 24'h7fffff;
          kind_min:  a_w = 24'h800000;
          kind_neg1: a_w = 24'hffffff;
          kind_mix:  a_w = 24'h800000;
          default:   a_w = $random(seed);
        endcase
        case (kind)
          kind_zero: b_w = 16'h0000;
          kind_max:  b_w = 16'h7fff;
          kind_min:  b_w = 16'h8000;
          kind_neg1: b_w = 16'hffff;
          kind_mix:  b_w = 16'h7fff;
          default:   b_w = $random(seed);
        endcase
      end else begin
        // Fabric lanes, B max is the top unsigned byte
        case (kind)
          kind_zero: la = 16'h0000;
          kind_max:  la = 16'h7fff;
          kind_min:  la = 16'h8000;
          kind_neg1: la = 16'hffff;
          kind_mix:  la = 16'h7fff;
          default:   la = $random(seed);
        endcase
        case (kind)
          kind_zero: lb = 8'h00;
          kind_max:  lb = 8'hff;
          kind_min:  lb = 8'hff;
          kind_neg1: lb = 8'hff;
          kind_mix:  lb = 8'h80;
          default:   lb = $random(seed);
        endcase
        // Junk in the ignored upper bits, always
        a_w = $random(seed);
        b_w = $random(seed);
        a_w[mult_pkg::lut_a_width-1:0] = la;
        b_w[mult_pkg::lut_b_width-1:0] = lb;
      end
      va[i*mult_pkg::a_width +: mult_pkg::a_width] = a_w;
      vb[i*mult_pkg::b_width +: mult_pkg::b_width] = b_w;
    end
  endtask

  initial begin
    seed      = 25135;
    tb_errors = 0;
    rst       = 1'b1;
    en        = 1'b0;
    vector_a  = '0;
    vector_b  = '0;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst = 1'b0;
    for (int r = 0; r < row_num; r++) begin
      en = stim_tbl[r][3];
      build_operands(stim_tbl[r][2:0], vector_a, vector_b);
      @(posedge clk);
      #drive_delay;
    end
    // Flush the words still in flight
    en       = 1'b1;
    vector_a = '0;
    vector_b = '0;
    repeat (mult_pkg::mult_latency) begin
      @(posedge clk);
      #drive_delay;
    end
    en = 1'b0;
    // Let the checker see the last output word
    @(negedge clk);
    #drive_delay;
    if (compare_count == 0) begin
      $display("Error: the checker compared no output words");
      tb_errors++;
    end
    sva_errors = dut_i.u_array.sva_i.fail_count;
    $display("Summary: %0d mismatches in %0d compares, %0d assertion failures, %0d other errors",
             error_count, compare_count, sva_errors, tb_errors);
    if (error_count == 0 && tb_errors == 0 && sva_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  ////////////////////
  // Timeout
  ////////////////////

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles, %0d mismatches so far",
             timeout_cycles, error_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* sources.f */
design/mult_pkg.sv
design/mult_lane_if.sv
design/mult_dsp_s24_s18.sv
design/mult_lut_s16_u8.sv
design/mult_array_hete.sv
design/mult_array_top.sv
tb/mult_array_sva.sv
tb/mult_array_checker.sv
tb/tb_mult_array.sv
